// File: build.f
+incdir+dv
hw/cutter_pkg.sv
hw/fifo_word_if.sv
hw/pkt_fifo.sv
hw/cut_ctrl.sv
hw/packet_cutter.sv
dv/tb_packet_cutter.sv

// File: run_sim.sh
#!/bin/sh
# Builds the packet truncator testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -j 0 --top-module tb_packet_cutter -f build.f

status=0
obj_dir/Vtb_packet_cutter > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Done: errors found" sim.log; then
   echo "Simulation failed"
   exit 1
fi
echo "Simulation passed"

// File: dv/tb_stim_table.svh
/*
 * Packet cases for the truncator testbench with the expected
 * length field, output word count and last-word strobe
 */

`ifndef TB_STIM_TABLE_SVH
`define TB_STIM_TABLE_SVH

typedef struct packed {
   logic [15:0] pkt_len;
   logic        cut_en;
   logic [15:0] cut_bytes;
   logic [15:0] exp_len;
   logic [10:0] exp_words;
   logic [31:0] exp_strb;
} packet_case_t;

localparam int NUM_TESTS = 12;

// Columns: input bytes, cut_en, cut_bytes, expected length field,
// expected output words, expected strobe of the last output word
localparam packet_case_t PACKET_CASES [NUM_TESTS] = '{
   '{16'd200,  1'b0, 16'd100,  16'd200,  11'd7,  32'hFF00_0000},
   '{16'd300,  1'b1, 16'd100,  16'd100,  11'd4,  32'hF000_0000},
   '{16'd500,  1'b1, 16'd128,  16'd128,  11'd4,  32'hFFFF_FFFF},
   '{16'd150,  1'b1, 16'd40,   16'd150,  11'd5,  32'hFFFF_FC00},
   '{16'd96,   1'b1, 16'd96,   16'd96,   11'd3,  32'hFFFF_FFFF},
   '{16'd80,   1'b1, 16'd200,  16'd80,   11'd3,  32'hFFFF_0000},
   '{16'd1000, 1'b1, 16'd65,   16'd65,   11'd3,  32'h8000_0000},
   '{16'd32,   1'b0, 16'd64,   16'd32,   11'd1,  32'hFFFF_FFFF},
   '{16'd33,   1'b1, 16'd64,   16'd33,   11'd2,  32'h8000_0000},
   '{16'd2048, 1'b1, 16'd2000, 16'd2000, 11'd63, 32'hFFFF_0000},
   '{16'd100,  1'b1, 16'd70,   16'd70,   11'd3,  32'hFC00_0000},
   '{16'd64,   1'b1, 16'd64,   16'd64,   11'd2,  32'hFFFF_FFFF}
};

`endif

// File: dv/tb_packet_cutter.sv
/*
 * Testbench for the packet truncator: table-driven packet driver,
 * random output back-pressure, per-packet monitor and checks
 */

`timescale 1ns/1ps

module tb_packet_cutter;

   localparam int          CLK_HALF  = 5;
   localparam logic [31:0] LFSR_SEED = 32'h442cf8dc;
   localparam int          WD_MARGIN = 200;
   localparam int          BP_LEN    = 1024;

   `include "tb_stim_table.svh"

   logic                 axi_aclk;
   logic                 axi_resetn;
   cutter_pkg::data_t    s_axis_tdata;
   cutter_pkg::strb_t    s_axis_tstrb;
   cutter_pkg::tuser_t   s_axis_tuser;
   logic                 s_axis_tvalid;
   logic                 s_axis_tready;
   logic                 s_axis_tlast;
   cutter_pkg::data_t    m_axis_tdata;
   cutter_pkg::strb_t    m_axis_tstrb;
   cutter_pkg::tuser_t   m_axis_tuser;
   logic                 m_axis_tvalid;
   logic                 m_axis_tready;
   logic                 m_axis_tlast;
   logic                 cut_en;
   cutter_pkg::pkt_len_t cut_bytes;

   // Input words of every packet, built before the run starts
   cutter_pkg::data_t    in_data [$];
   cutter_pkg::strb_t    in_strb [$];
   cutter_pkg::tuser_t   in_tuser [$];
   logic                 in_last [$];
   int                   pkt_base [NUM_TESTS];
   logic                 bp_ready [BP_LEN];

   // Words of the packet currently leaving the DUT
   cutter_pkg::data_t    out_data [$];
   cutter_pkg::strb_t    out_strb [$];
   cutter_pkg::tuser_t   out_tuser [$];

   logic [31:0]          lfsr_state;
   int                   first_words_out;
   int                   check_count;
   int                   error_count;

   packet_cutter dut0 (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .s_axis_tdata  (s_axis_tdata),
      .s_axis_tstrb  (s_axis_tstrb),
      .s_axis_tuser  (s_axis_tuser),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .s_axis_tlast  (s_axis_tlast),
      .m_axis_tdata  (m_axis_tdata),
      .m_axis_tstrb  (m_axis_tstrb),
      .m_axis_tuser  (m_axis_tuser),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready),
      .m_axis_tlast  (m_axis_tlast),
      .cut_en        (cut_en),
      .cut_bytes     (cut_bytes)
   );

   initial axi_aclk = 1'b0;
   always #CLK_HALF axi_aclk = ~axi_aclk;

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [255:0] v);
      int i;
      v = '0;
      for (i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[254:0], lfsr_state[0]};
      end
   endtask

   function automatic int words_of(input cutter_pkg::pkt_len_t len);
      return (int'(len) + 31) / 32;
   endfunction

   // Top (len mod 32) byte lanes, or the whole word
   function automatic cutter_pkg::strb_t top_strb(input int len);
      cutter_pkg::strb_t s;
      int rem;
      int i;
      rem = len % 32;
      s = '0;
      if (rem == 0) begin
         s = {cutter_pkg::STRB_WIDTH{1'b1}};
      end else begin
         for (i = 0; i < rem; i++) begin
            s[31-i] = 1'b1;
         end
      end
      return s;
   endfunction

   function automatic int total_in_words();
      int t;
      int sum;
      sum = 0;
      for (t = 0; t < NUM_TESTS; t++) begin
         sum += words_of(PACKET_CASES[t].pkt_len);
      end
      return sum;
   endfunction

   task automatic build_stimulus();
      int t;
      int w;
      int nw;
      int c;
      logic [255:0] bits;
      lfsr_state = LFSR_SEED;
      for (t = 0; t < NUM_TESTS; t++) begin
         pkt_base[t] = in_data.size();
         nw = words_of(PACKET_CASES[t].pkt_len);
         for (w = 0; w < nw; w++) begin
            take_bits(256, bits);
            in_data.push_back(bits);
            take_bits(128, bits);
            // Length field on the first word only
            if (w == 0) begin
               bits[15:0] = PACKET_CASES[t].pkt_len;
            end
            in_tuser.push_back(bits[127:0]);
            in_strb.push_back((w == nw - 1) ? top_strb(int'(PACKET_CASES[t].pkt_len))
                                            : {cutter_pkg::STRB_WIDTH{1'b1}});
            in_last.push_back(w == nw - 1);
         end
      end
      // Ready low about one cycle in four
      for (c = 0; c < BP_LEN; c++) begin
         take_bits(2, bits);
         bp_ready[c] = (bits[1:0] != 2'b11);
      end
   endtask

   task automatic check_value(input string name, input logic [255:0] got,
                              input logic [255:0] exp);
      check_count++;
      if (got !== exp) begin
         $display("CHECK FAILED %s: got %0h expected %0h", name, got, exp);
         error_count++;
      end
   endtask

   task automatic check_packet(input int t);
      packet_case_t       pc;
      int                 base;
      int                 n;
      int                 i;
      logic               was_cut;
      cutter_pkg::tuser_t exp_tuser;
      cutter_pkg::strb_t  exp_strb;
      pc = PACKET_CASES[t];
      base = pkt_base[t];
      n = out_data.size();
      was_cut = (pc.exp_len != pc.pkt_len);
      check_value("output word count", 256'(n), 256'(pc.exp_words));
      for (i = 0; i < n && i < int'(pc.exp_words); i++) begin
         if (i == 0) begin
            exp_tuser = {in_tuser[base][cutter_pkg::TUSER_WIDTH-1:cutter_pkg::LEN_WIDTH],
                         pc.exp_len};
         end else begin
            exp_tuser = was_cut ? '0 : in_tuser[base + i];
         end
         exp_strb = (i == int'(pc.exp_words) - 1) ? pc.exp_strb : in_strb[base + i];
         check_value($sformatf("m_axis_tdata[%0d]", i), out_data[i], in_data[base + i]);
         check_value($sformatf("m_axis_tuser[%0d]", i), 256'(out_tuser[i]), 256'(exp_tuser));
         check_value($sformatf("m_axis_tstrb[%0d]", i), 256'(out_strb[i]), 256'(exp_strb));
      end
   endtask

   initial begin : driver
      int t;
      int w;
      int nw;
      axi_resetn    = 1'b0;
      s_axis_tdata  = '0;
      s_axis_tstrb  = '0;
      s_axis_tuser  = '0;
      s_axis_tvalid = 1'b0;
      s_axis_tlast  = 1'b0;
      m_axis_tready = 1'b0;
      cut_en        = 1'b0;
      cut_bytes     = '0;
      build_stimulus();
      repeat (5) @(posedge axi_aclk);
      axi_resetn <= 1'b1;
      for (t = 0; t < NUM_TESTS; t++) begin
         nw = words_of(PACKET_CASES[t].pkt_len);
         @(posedge axi_aclk);
         cut_en    <= PACKET_CASES[t].cut_en;
         cut_bytes <= PACKET_CASES[t].cut_bytes;
         for (w = 0; w < nw; w++) begin
            s_axis_tdata  <= in_data[pkt_base[t] + w];
            s_axis_tstrb  <= in_strb[pkt_base[t] + w];
            s_axis_tuser  <= in_tuser[pkt_base[t] + w];
            s_axis_tlast  <= in_last[pkt_base[t] + w];
            s_axis_tvalid <= 1'b1;
            do begin
               @(posedge axi_aclk);
            end while (!s_axis_tready);
         end
         s_axis_tvalid <= 1'b0;
         // Controls must hold until the first word has left the FIFO head
         while (first_words_out <= t) begin
            @(posedge axi_aclk);
         end
      end
   end

   initial begin : backpressure
      int cycle;
      cycle = 0;
      forever begin
         @(posedge axi_aclk);
         m_axis_tready <= bp_ready[cycle % BP_LEN];
         cycle++;
      end
   end

   initial begin : monitor
      int   t;
      int   errs_before;
      logic done;
      first_words_out = 0;
      check_count     = 0;
      error_count     = 0;
      wait (axi_resetn === 1'b1);
      for (t = 0; t < NUM_TESTS; t++) begin
         errs_before = error_count;
         out_data.delete();
         out_strb.delete();
         out_tuser.delete();
         done = 1'b0;
         while (!done) begin
            @(posedge axi_aclk);
            if (m_axis_tvalid && m_axis_tready) begin
               if (out_data.size() == 0) begin
                  first_words_out <= first_words_out + 1;
               end
               out_data.push_back(m_axis_tdata);
               out_strb.push_back(m_axis_tstrb);
               out_tuser.push_back(m_axis_tuser);
               done = m_axis_tlast;
            end
         end
         check_packet(t);
         $display("test %0d: %0d bytes, cut_en %0b, cut_bytes %0d, %0d words out, %s",
                  t, PACKET_CASES[t].pkt_len, PACKET_CASES[t].cut_en,
                  PACKET_CASES[t].cut_bytes, out_data.size(),
                  (error_count == errs_before) ? "ok" : "FAILED");
      end
      // Nothing may follow the last packet
      repeat (20) @(posedge axi_aclk);
      check_value("m_axis_tvalid after last packet", 256'(m_axis_tvalid), 256'(0));
      $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, check_count, error_count);
      if (error_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   initial begin : watchdog
      int limit;
      limit = total_in_words() * 20 + WD_MARGIN;
      repeat (limit) @(posedge axi_aclk);
      $display("Timeout: the packets did not all come out within %0d cycles", limit);
      $display("Done: errors found");
      $finish;
   end

endmodule

// File: hw/packet_cutter.sv
/*
 * AXI-Stream packet truncator top: input FIFO feeding the
 * cut controller, FIFO depth set here
 */

`timescale 1ns/1ps

module packet_cutter #(
   parameter int FIFO_DEPTH_BITS = 3
) (
   input  logic                 axi_aclk,
   input  logic                 axi_resetn,

   // Slave stream from the receive side
   input  cutter_pkg::data_t    s_axis_tdata,
   input  cutter_pkg::strb_t    s_axis_tstrb,
   input  cutter_pkg::tuser_t   s_axis_tuser,
   input  logic                 s_axis_tvalid,
   output logic                 s_axis_tready,
   input  logic                 s_axis_tlast,

   // Master stream towards the datapath
   output cutter_pkg::data_t    m_axis_tdata,
   output cutter_pkg::strb_t    m_axis_tstrb,
   output cutter_pkg::tuser_t   m_axis_tuser,
   output logic                 m_axis_tvalid,
   input  logic                 m_axis_tready,
   output logic                 m_axis_tlast,

   // Sampled on the first word of each packet
   input  logic                 cut_en,
   input  cutter_pkg::pkt_len_t cut_bytes
);

   fifo_word_if head_if ();

   pkt_fifo #(
      .FIFO_DEPTH_BITS (FIFO_DEPTH_BITS)
   ) fifo0 (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .in_tdata   (s_axis_tdata),
      .in_tstrb   (s_axis_tstrb),
      .in_tuser   (s_axis_tuser),
      .in_tlast   (s_axis_tlast),
      .in_valid   (s_axis_tvalid),
      .in_ready   (s_axis_tready),
      .head       (head_if.fifo)
   );

   cut_ctrl ctrl0 (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .head       (head_if.ctrl),
      .cut_en     (cut_en),
      .cut_bytes  (cut_bytes),
      .m_tdata    (m_axis_tdata),
      .m_tstrb    (m_axis_tstrb),
      .m_tuser    (m_axis_tuser),
      .m_tvalid   (m_axis_tvalid),
      .m_tready   (m_axis_tready),
      .m_tlast    (m_axis_tlast)
   );

endmodule

// File: hw/cut_ctrl.sv
/*
 * Cut decision on the first word, kept word counting, output mux
 * with length rewrite and tail strobe, drain of the discarded tail
 */

`timescale 1ns/1ps

module cut_ctrl (
   input  logic                 axi_aclk,
   input  logic                 axi_resetn,
   fifo_word_if.ctrl            head,
   input  logic                 cut_en,
   input  cutter_pkg::pkt_len_t cut_bytes,
   output cutter_pkg::data_t    m_tdata,
   output cutter_pkg::strb_t    m_tstrb,
   output cutter_pkg::tuser_t   m_tuser,
   output logic                 m_tvalid,
   input  logic                 m_tready,
   output logic                 m_tlast
);

   cutter_pkg::cut_state_t state;
   cutter_pkg::cut_state_t state_next;
   cutter_pkg::word_cnt_t  word_cnt;
   cutter_pkg::word_cnt_t  word_cnt_next;
   cutter_pkg::word_cnt_t  last_idx;
   cutter_pkg::word_cnt_t  last_idx_next;
   cutter_pkg::strb_t      tail_strb;
   cutter_pkg::strb_t      tail_strb_next;

   cutter_pkg::pkt_len_t   in_len;
   cutter_pkg::pkt_len_t   cut_bytes_m1;
   cutter_pkg::word_cnt_t  cut_last_idx;
   cutter_pkg::strb_t      cut_tail_strb;
   logic [cutter_pkg::BYTE_IDX_WIDTH-1:0] cut_rem;
   logic                   do_cut;
   logic                   body_last;

   assign in_len = head.tuser[cutter_pkg::LEN_WIDTH-1:0];
   assign do_cut = cut_en && (in_len > cut_bytes)
                   && (cut_bytes >= cutter_pkg::MIN_CUT_BYTES);

   // Index of the last kept word is floor((cut_bytes - 1) / 32)
   assign cut_bytes_m1 = cut_bytes - 1'b1;
   assign cut_last_idx = cut_bytes_m1[cutter_pkg::LEN_WIDTH-1:cutter_pkg::BYTE_IDX_WIDTH];

   // Top bytes of the final word, whole word on an exact multiple
   assign cut_rem       = cut_bytes[cutter_pkg::BYTE_IDX_WIDTH-1:0];
   assign cut_tail_strb = (cut_rem == '0) ? {cutter_pkg::STRB_WIDTH{1'b1}}
                                          : ~({cutter_pkg::STRB_WIDTH{1'b1}} >> cut_rem);

   assign body_last  = (word_cnt == last_idx);

   always_comb begin
      m_tdata        = head.tdata;
      m_tstrb        = head.tstrb;
      m_tuser        = head.tuser;
      m_tlast        = head.tlast;
      m_tvalid       = 1'b0;
      head.rd_en     = 1'b0;
      state_next     = state;
      word_cnt_next  = word_cnt;
      last_idx_next  = last_idx;
      tail_strb_next = tail_strb;

      case (state)
         cutter_pkg::PASS_FIRST: begin
            if (!head.empty) begin
               m_tvalid = 1'b1;
               if (do_cut) begin
                  m_tuser[cutter_pkg::LEN_WIDTH-1:0] = cut_bytes;
               end
               if (m_tready) begin
                  head.rd_en = 1'b1;
                  if (head.tlast) begin
                     state_next = cutter_pkg::PASS_FIRST;
                  end else if (do_cut) begin
                     state_next = cutter_pkg::CUT_BODY;
                  end else begin
                     state_next = cutter_pkg::PASS_BODY;
                  end
                  // First word already sent, count from one
                  if (do_cut) begin
                     word_cnt_next  = cutter_pkg::word_cnt_t'(1);
                     last_idx_next  = cut_last_idx;
                     tail_strb_next = cut_tail_strb;
                  end
               end
            end
         end

         cutter_pkg::PASS_BODY: begin
            if (!head.empty) begin
               m_tvalid = 1'b1;
               if (m_tready) begin
                  head.rd_en = 1'b1;
                  if (head.tlast) begin
                     state_next = cutter_pkg::PASS_FIRST;
                  end
               end
            end
         end

         cutter_pkg::CUT_BODY: begin
            if (!head.empty) begin
               m_tvalid = 1'b1;
               m_tuser  = '0;
               if (body_last) begin
                  m_tlast = 1'b1;
                  m_tstrb = tail_strb;
               end
               if (m_tready) begin
                  head.rd_en    = 1'b1;
                  word_cnt_next = word_cnt + 1'b1;
                  if (head.tlast) begin
                     state_next = cutter_pkg::PASS_FIRST;
                  end else if (body_last) begin
                     state_next = cutter_pkg::DRAIN;
                  end
               end
            end
         end

         // Remainder of the input packet is consumed without output
         cutter_pkg::DRAIN: begin
            if (!head.empty) begin
               head.rd_en = 1'b1;
               if (head.tlast) begin
                  state_next = cutter_pkg::PASS_FIRST;
               end
            end
         end

         default: begin
            state_next = cutter_pkg::PASS_FIRST;
         end
      endcase
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state     <= cutter_pkg::PASS_FIRST;
         word_cnt  <= '0;
         last_idx  <= '0;
         tail_strb <= '0;
      end else begin
         state     <= state_next;
         word_cnt  <= word_cnt_next;
         last_idx  <= last_idx_next;
         tail_strb <= tail_strb_next;
      end
   end

   // A stalled output word stays on the bus until it is taken
   a_hold_under_backpressure: assert property (
      @(posedge axi_aclk) disable iff (!axi_resetn)
      m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast)
   );

   // A cut packet never runs past its kept word count
   a_cut_within_kept: assert property (
      @(posedge axi_aclk) disable iff (!axi_resetn)
      (state == cutter_pkg::CUT_BODY) |-> (word_cnt <= last_idx)
   );

endmodule

// File: hw/pkt_fifo.sv
/*
 * Fall-through FIFO of whole stream words with a nearly-full
 * flag driving the upstream ready
 */

`timescale 1ns/1ps

module pkt_fifo #(
   parameter int FIFO_DEPTH_BITS = 3
) (
   input  logic               axi_aclk,
   input  logic               axi_resetn,
   input  cutter_pkg::data_t  in_tdata,
   input  cutter_pkg::strb_t  in_tstrb,
   input  cutter_pkg::tuser_t in_tuser,
   input  logic               in_tlast,
   input  logic               in_valid,
   output logic               in_ready,
   fifo_word_if.fifo          head
);

   localparam int DEPTH = 1 << FIFO_DEPTH_BITS;
   localparam logic [FIFO_DEPTH_BITS:0] FULL_LVL        = (FIFO_DEPTH_BITS+1)'(DEPTH);
   localparam logic [FIFO_DEPTH_BITS:0] NEARLY_FULL_LVL = (FIFO_DEPTH_BITS+1)'(DEPTH - 1);

   cutter_pkg::data_t  mem_tdata [DEPTH];
   cutter_pkg::strb_t  mem_tstrb [DEPTH];
   cutter_pkg::tuser_t mem_tuser [DEPTH];
   logic               mem_tlast [DEPTH];

   logic [FIFO_DEPTH_BITS-1:0] wr_ptr;
   logic [FIFO_DEPTH_BITS-1:0] rd_ptr;
   logic [FIFO_DEPTH_BITS:0]   count;
   logic                       wr_en;

   // Keep one slot spare so ready can drop a cycle late
   assign in_ready = (count < NEARLY_FULL_LVL);
   assign wr_en    = in_valid && in_ready;

   // Head word is read straight from the array
   assign head.tdata = mem_tdata[rd_ptr];
   assign head.tstrb = mem_tstrb[rd_ptr];
   assign head.tuser = mem_tuser[rd_ptr];
   assign head.tlast = mem_tlast[rd_ptr];
   assign head.empty = (count == '0);

   always_ff @(posedge axi_aclk) begin
      if (wr_en) begin
         mem_tdata[wr_ptr] <= in_tdata;
         mem_tstrb[wr_ptr] <= in_tstrb;
         mem_tuser[wr_ptr] <= in_tuser;
         mem_tlast[wr_ptr] <= in_tlast;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (head.rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Simultaneous push and pop leaves the level unchanged
         case ({wr_en, head.rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Fill level never exceeds the depth and tracks the pointer distance
   a_level_matches_ptrs: assert property (
      @(posedge axi_aclk) disable iff (!axi_resetn)
      (count <= FULL_LVL) && (count[FIFO_DEPTH_BITS-1:0] == wr_ptr - rd_ptr)
   );

   // Consumer must only pop a word that is present
   a_no_read_when_empty: assert property (
      @(posedge axi_aclk) disable iff (!axi_resetn)
      head.rd_en |-> !head.empty
   );

endmodule

// File: hw/fifo_word_if.sv
/*
 * Head-of-FIFO word bundle: payload, last flag, empty flag
 * and the pop strobe from the consumer
 */

`timescale 1ns/1ps

interface fifo_word_if;

   // Oldest buffered word, valid while empty is low
   cutter_pkg::data_t  tdata;
   cutter_pkg::strb_t  tstrb;
   cutter_pkg::tuser_t tuser;
   logic               tlast;
   logic               empty;

   // Pops the head word at the next clock edge
   logic               rd_en;

   modport fifo (
      output tdata,
      output tstrb,
      output tuser,
      output tlast,
      output empty,
      input  rd_en
   );

   modport ctrl (
      input  tdata,
      input  tstrb,
      input  tuser,
      input  tlast,
      input  empty,
      output rd_en
   );

endinterface

// File: hw/cutter_pkg.sv
/*
 * Shared widths, vector types, controller states and the
 * minimum cut length for the packet truncator
 */

package cutter_pkg;

   // Stream word geometry
   localparam int DATA_WIDTH     = 256;
   localparam int STRB_WIDTH     = DATA_WIDTH / 8;
   localparam int TUSER_WIDTH    = 128;

   // Length field sits in the low bits of tuser on the first word
   localparam int LEN_WIDTH      = 16;
   localparam int BYTE_IDX_WIDTH = 5;

   typedef logic [DATA_WIDTH-1:0]  data_t;

   // MSB is the first byte of the word
   typedef logic [STRB_WIDTH-1:0]  strb_t;

   typedef logic [TUSER_WIDTH-1:0] tuser_t;
   typedef logic [LEN_WIDTH-1:0]   pkt_len_t;

   // Enough for the word index of any 64 KB packet
   typedef logic [LEN_WIDTH-BYTE_IDX_WIDTH-1:0] word_cnt_t;

   // Shorter cut requests are ignored
   localparam pkt_len_t MIN_CUT_BYTES = 16'd64;

   typedef enum logic [1:0] {
      PASS_FIRST = 2'd0,
      PASS_BODY  = 2'd1,
      CUT_BODY   = 2'd2,
      DRAIN      = 2'd3
   } cut_state_t;

endpackage
